/* Bender.yml */
package:
  name: soc_devices

sources:
  - hdl/soc_pkg.sv
  - hdl/soc_bus.sv
  - hdl/soc_ram.sv
  - hdl/soc_gpio.sv
  - hdl/soc_mtimer.sv
  - hdl/soc_top.sv
  - target: test
    files:
      - testbench/soc_bus_sva.sv
      - testbench/soc_tb.sv

/* hdl/soc_bus.sv */
/*
  System bus between one manager and the managed devices.
  Decodes the request address against the address map and forwards the
  request to a single device in the same cycle. One cycle later it
  returns that device's read data and response to the manager, or a
  zero reply of its own when no region matched.
*/

`timescale 1ns/1ps

module soc_bus #(
  parameter int memory_size = 4096
) (
  input  logic                                          clock,
  input  logic                                          rst,

  // Manager side
  input  logic [31:0]                                   manager_rw_address,
  input  logic [soc_pkg::data_width-1:0]                manager_write_data,
  input  logic [soc_pkg::strobe_width-1:0]              manager_write_strobe,
  input  logic                                          manager_read_request,
  input  logic                                          manager_write_request,
  output logic [soc_pkg::data_width-1:0]                manager_read_data,
  output logic                                          manager_read_response,
  output logic                                          manager_write_response,

  // Device side
  output logic [31:0]                                   device_rw_address,
  output logic [soc_pkg::data_width-1:0]                device_write_data,
  output logic [soc_pkg::strobe_width-1:0]              device_write_strobe,
  output logic [soc_pkg::num_devices-1:0]               device_read_request,
  output logic [soc_pkg::num_devices-1:0]               device_write_request,
  input  logic [soc_pkg::num_devices*soc_pkg::data_width-1:0] device_read_data,
  input  logic [soc_pkg::num_devices-1:0]               device_read_response,
  input  logic [soc_pkg::num_devices-1:0]               device_write_response
);

  import soc_pkg::*;

  logic [num_devices-1:0] device_select;
  logic                   unmapped;
  logic [num_devices-1:0] selected_q;
  logic                   unmapped_read_q;
  logic                   unmapped_write_q;

  // ------------------------------------------------------------------
  // Address decode and request routing
  // ------------------------------------------------------------------

  always_comb begin
    device_select             = '0;
    device_select[dev_ram]    = (manager_rw_address - ram_start) < 32'(memory_size);
    device_select[dev_mtimer] = (manager_rw_address - mtimer_start) < mtimer_size;
    device_select[dev_gpio]   = (manager_rw_address - gpio_start) < gpio_size;
  end

  assign unmapped = ~|device_select;

  assign device_rw_address    = manager_rw_address;
  assign device_write_data    = manager_write_data;
  assign device_write_strobe  = manager_write_strobe;
  assign device_read_request  = device_select & {num_devices{manager_read_request}};
  assign device_write_request = device_select & {num_devices{manager_write_request}};

  // ------------------------------------------------------------------
  // Response path
  // ------------------------------------------------------------------

  // Remember who owns the response cycle
  always_ff @(posedge clock) begin
    if (rst) begin
      selected_q       <= '0;
      unmapped_read_q  <= 1'b0;
      unmapped_write_q <= 1'b0;
    end else begin
      selected_q       <= device_read_request | device_write_request;
      unmapped_read_q  <= manager_read_request & unmapped;
      unmapped_write_q <= manager_write_request & unmapped;
    end
  end

  // Unmapped reads fall through to zero
  always_comb begin
    manager_read_data = '0;
    for (int i = 0; i < num_devices; i++) begin
      if (selected_q[i]) begin
        manager_read_data = device_read_data[data_width*i +: data_width];
      end
    end
  end

  assign manager_read_response  = |(device_read_response & selected_q) | unmapped_read_q;
  assign manager_write_response = |(device_write_response & selected_q) | unmapped_write_q;

endmodule

/* hdl/soc_gpio.sv */
/*
  GPIO block on the system bus.
  Offset 0 reads the synchronised input pins, offset 4 holds the output
  enables and offset 8 the output values. Writes need strobe byte 0.
*/

`timescale 1ns/1ps

module soc_gpio #(
  parameter int gpio_width = 4
) (
  input  logic                              clock,
  input  logic                              rst,
  input  logic [31:0]                       rw_address,
  input  logic [soc_pkg::data_width-1:0]    write_data,
  input  logic [soc_pkg::strobe_width-1:0]  write_strobe,
  input  logic                              read_request,
  input  logic                              write_request,
  output logic [soc_pkg::data_width-1:0]    read_data,
  output logic                              read_response,
  output logic                              write_response,
  input  logic [gpio_width-1:0]             gpio_input,
  output logic [gpio_width-1:0]             gpio_oe,
  output logic [gpio_width-1:0]             gpio_output
);

  import soc_pkg::*;

  localparam logic [4:0] reg_input  = 5'd0;
  localparam logic [4:0] reg_oe     = 5'd4;
  localparam logic [4:0] reg_output = 5'd8;

  logic [gpio_width-1:0] gpio_meta;
  logic [gpio_width-1:0] gpio_sync;

  // Two-stage synchroniser for the pins
  always_ff @(posedge clock) begin
    gpio_meta <= gpio_input;
    gpio_sync <= gpio_meta;
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      gpio_oe        <= '0;
      gpio_output    <= '0;
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      read_response  <= read_request;
      write_response <= write_request;
      if (write_request && write_strobe[0]) begin
        if (rw_address[4:0] == reg_oe)     gpio_oe     <= write_data[gpio_width-1:0];
        if (rw_address[4:0] == reg_output) gpio_output <= write_data[gpio_width-1:0];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (read_request) begin
      case (rw_address[4:0])
        reg_input:  read_data <= data_width'(gpio_sync);
        reg_oe:     read_data <= data_width'(gpio_oe);
        reg_output: read_data <= data_width'(gpio_output);
        default:    read_data <= '0;
      endcase
    end
  end

endmodule

/* hdl/soc_mtimer.sv */
/*
  RISC-V machine timer on the system bus.
  A 64-bit mtime counts while enabled and is compared with mtimecmp.
  irq is registered and follows "enabled and mtime >= mtimecmp".
  Offset 0 is control, 4 and 8 hold mtime low and high, and 12 and 16
  hold mtimecmp low and high.
*/

`timescale 1ns/1ps

module soc_mtimer (
  input  logic                              clock,
  input  logic                              rst,
  input  logic [31:0]                       rw_address,
  input  logic [soc_pkg::data_width-1:0]    write_data,
  input  logic [soc_pkg::strobe_width-1:0]  write_strobe,
  input  logic                              read_request,
  input  logic                              write_request,
  output logic [soc_pkg::data_width-1:0]    read_data,
  output logic                              read_response,
  output logic                              write_response,
  output logic                              irq
);

  import soc_pkg::*;

  localparam logic [4:0] reg_control = 5'd0;
  localparam logic [4:0] reg_time_lo = 5'd4;
  localparam logic [4:0] reg_time_hi = 5'd8;
  localparam logic [4:0] reg_cmp_lo  = 5'd12;
  localparam logic [4:0] reg_cmp_hi  = 5'd16;

  logic        enable;
  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic [31:0] merged_low;
  logic [31:0] merged_high;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_value,
                                              input logic [31:0] new_value,
                                              input logic [3:0]  strobe);
    logic [31:0] result;
    result = old_value;
    for (int i = 0; i < strobe_width; i++) begin
      if (strobe[i]) result[8*i +: 8] = new_value[8*i +: 8];
    end
    return result;
  endfunction

  // Merged halves for whichever 64-bit register is addressed
  assign merged_low  = merge_bytes(rw_address[4:0] == reg_time_lo ? mtime[31:0]
                                   : mtimecmp[31:0], write_data, write_strobe);
  assign merged_high = merge_bytes(rw_address[4:0] == reg_time_hi ? mtime[63:32]
                                   : mtimecmp[63:32], write_data, write_strobe);

  always_ff @(posedge clock) begin
    if (rst) begin
      enable         <= 1'b0;
      mtime          <= '0;
      mtimecmp       <= '0;
      irq            <= 1'b0;
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      read_response  <= read_request;
      write_response <= write_request;
      irq            <= enable && (mtime >= mtimecmp);
      // A software write to mtime wins over the count
      if (write_request && rw_address[4:0] == reg_time_lo) mtime <= {mtime[63:32], merged_low};
      else if (write_request && rw_address[4:0] == reg_time_hi) mtime <= {merged_high, mtime[31:0]};
      else if (enable) mtime <= mtime + 64'd1;
      if (write_request) begin
        case (rw_address[4:0])
          reg_control: if (write_strobe[0]) enable <= write_data[0];
          reg_cmp_lo:  mtimecmp[31:0]  <= merged_low;
          reg_cmp_hi:  mtimecmp[63:32] <= merged_high;
          default:     ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (read_request) begin
      case (rw_address[4:0])
        reg_control: read_data <= {31'b0, enable};
        reg_time_lo: read_data <= mtime[31:0];
        reg_time_hi: read_data <= mtime[63:32];
        reg_cmp_lo:  read_data <= mtimecmp[31:0];
        reg_cmp_hi:  read_data <= mtimecmp[63:32];
        default:     read_data <= '0;
      endcase
    end
  end

endmodule

/* hdl/soc_pkg.sv */
/*
  Shared definitions for the memory-mapped device side of the SoC.
  Holds the device indices, the fixed address map and the bus widths.
  The RAM region size comes from the memory_size parameter instead.
  Modules import it with a wildcard inside their body.
*/

package soc_pkg;

  // ------------------------------------------------------------------
  // Managed devices
  // ------------------------------------------------------------------

  localparam int num_devices = 3;

  localparam int dev_ram    = 0;
  localparam int dev_mtimer = 1;
  localparam int dev_gpio   = 2;

  // ------------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------------

  localparam logic [31:0] ram_start    = 32'h0000_0000;
  localparam logic [31:0] mtimer_start = 32'h8001_0000;
  localparam logic [31:0] gpio_start   = 32'h8002_0000;

  // Both peripheral regions span 32 bytes
  localparam logic [31:0] mtimer_size = 32'd32;
  localparam logic [31:0] gpio_size   = 32'd32;

  // Bus widths
  localparam int data_width   = 32;
  localparam int strobe_width = 4;

endpackage

/* hdl/soc_ram.sv */
/*
  Word-organised RAM on the system bus.
  Writes update only the bytes whose strobe bit is set. Read data and
  both responses are registered, so each request is answered exactly
  one cycle later. memory_size is in bytes and must be a power of 2.
*/

`timescale 1ns/1ps

module soc_ram #(
  parameter int memory_size = 4096
) (
  input  logic                              clock,
  input  logic                              rst,
  input  logic [31:0]                       rw_address,
  input  logic [soc_pkg::data_width-1:0]    write_data,
  input  logic [soc_pkg::strobe_width-1:0]  write_strobe,
  input  logic                              read_request,
  input  logic                              write_request,
  output logic [soc_pkg::data_width-1:0]    read_data,
  output logic                              read_response,
  output logic                              write_response
);

  import soc_pkg::*;

  localparam int addr_bits = $clog2(memory_size);

  logic [data_width-1:0] mem [memory_size/4];
  logic [addr_bits-3:0]  word_index;

  // Word-aligned byte address bits below the region size
  assign word_index = rw_address[addr_bits-1:2];

  always_ff @(posedge clock) begin
    if (write_request) begin
      for (int i = 0; i < strobe_width; i++) begin
        if (write_strobe[i]) begin
          mem[word_index][8*i +: 8] <= write_data[8*i +: 8];
        end
      end
    end
    if (read_request) begin
      read_data <= mem[word_index];
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      read_response  <= read_request;
      write_response <= write_request;
    end
  end

endmodule

/* hdl/soc_top.sv */
/*
  Device side of the SoC: system bus with RAM, machine timer and GPIO.
  The manager request/response port is exposed for an external core.
  Every request is answered exactly one cycle later.
*/

`timescale 1ns/1ps

module soc_top #(
  parameter int memory_size = 4096,
  parameter int gpio_width  = 4
) (
  input  logic                              clock,
  input  logic                              rst,

  // Manager port
  input  logic [31:0]                       rw_address,
  output logic [soc_pkg::data_width-1:0]    read_data,
  input  logic                              read_request,
  output logic                              read_response,
  input  logic [soc_pkg::data_width-1:0]    write_data,
  input  logic [soc_pkg::strobe_width-1:0]  write_strobe,
  input  logic                              write_request,
  output logic                              write_response,

  // Pins and interrupt
  input  logic [gpio_width-1:0]             gpio_input,
  output logic [gpio_width-1:0]             gpio_oe,
  output logic [gpio_width-1:0]             gpio_output,
  output logic                              irq_timer
);

  import soc_pkg::*;

  // ------------------------------------------------------------------
  // Bus to device wiring
  // ------------------------------------------------------------------

  logic [31:0]                       device_rw_address;
  logic [data_width-1:0]             device_write_data;
  logic [strobe_width-1:0]           device_write_strobe;
  logic [num_devices-1:0]            device_read_request;
  logic [num_devices-1:0]            device_write_request;
  logic [num_devices*data_width-1:0] device_read_data;
  logic [num_devices-1:0]            device_read_response;
  logic [num_devices-1:0]            device_write_response;

  soc_bus #(.memory_size(memory_size)) u_soc_bus (
    .clock                 (clock),
    .rst                   (rst),
    .manager_rw_address    (rw_address),
    .manager_write_data    (write_data),
    .manager_write_strobe  (write_strobe),
    .manager_read_request  (read_request),
    .manager_write_request (write_request),
    .manager_read_data     (read_data),
    .manager_read_response (read_response),
    .manager_write_response(write_response),
    .device_rw_address     (device_rw_address),
    .device_write_data     (device_write_data),
    .device_write_strobe   (device_write_strobe),
    .device_read_request   (device_read_request),
    .device_write_request  (device_write_request),
    .device_read_data      (device_read_data),
    .device_read_response  (device_read_response),
    .device_write_response (device_write_response)
  );

  soc_ram #(.memory_size(memory_size)) u_soc_ram (
    .clock         (clock),
    .rst           (rst),
    .rw_address    (device_rw_address),
    .write_data    (device_write_data),
    .write_strobe  (device_write_strobe),
    .read_request  (device_read_request[dev_ram]),
    .write_request (device_write_request[dev_ram]),
    .read_data     (device_read_data[data_width*dev_ram +: data_width]),
    .read_response (device_read_response[dev_ram]),
    .write_response(device_write_response[dev_ram])
  );

  soc_mtimer u_soc_mtimer (
    .clock         (clock),
    .rst           (rst),
    .rw_address    (device_rw_address),
    .write_data    (device_write_data),
    .write_strobe  (device_write_strobe),
    .read_request  (device_read_request[dev_mtimer]),
    .write_request (device_write_request[dev_mtimer]),
    .read_data     (device_read_data[data_width*dev_mtimer +: data_width]),
    .read_response (device_read_response[dev_mtimer]),
    .write_response(device_write_response[dev_mtimer]),
    .irq           (irq_timer)
  );

  soc_gpio #(.gpio_width(gpio_width)) u_soc_gpio (
    .clock         (clock),
    .rst           (rst),
    .rw_address    (device_rw_address),
    .write_data    (device_write_data),
    .write_strobe  (device_write_strobe),
    .read_request  (device_read_request[dev_gpio]),
    .write_request (device_write_request[dev_gpio]),
    .read_data     (device_read_data[data_width*dev_gpio +: data_width]),
    .read_response (device_read_response[dev_gpio]),
    .write_response(device_write_response[dev_gpio]),
    .gpio_input    (gpio_input),
    .gpio_oe       (gpio_oe),
    .gpio_output   (gpio_output)
  );

endmodule

/* src.f */
hdl/soc_pkg.sv
hdl/soc_bus.sv
hdl/soc_ram.sv
hdl/soc_gpio.sv
hdl/soc_mtimer.sv
hdl/soc_top.sv
testbench/soc_bus_sva.sv
testbench/soc_tb.sv

/* testbench/soc_bus_sva.sv */
/*
  Concurrent checks on the system bus handshake, bound to soc_bus.
  At most one device request at a time, never a read and a write
  together, and exactly one response one cycle after each request.
*/

`timescale 1ns/1ps

module soc_bus_sva (
  input logic                            clock,
  input logic                            rst,
  input logic                            manager_read_request,
  input logic                            manager_write_request,
  input logic                            manager_read_response,
  input logic                            manager_write_response,
  input logic [soc_pkg::num_devices-1:0] device_read_request,
  input logic [soc_pkg::num_devices-1:0] device_write_request
);

  // ------------------------------------------------------------------
  // Request side
  // ------------------------------------------------------------------

  one_device: assert property (@(posedge clock) disable iff (rst)
    $onehot0(device_read_request | device_write_request))
    else $error("more than one device request active");

  no_read_with_write: assert property (@(posedge clock) disable iff (rst)
    !(manager_read_request && manager_write_request))
    else $error("read and write requested together");

  // ------------------------------------------------------------------
  // Response side
  // ------------------------------------------------------------------

  read_answered: assert property (@(posedge clock) disable iff (rst)
    manager_read_request |=> manager_read_response && !manager_write_response)
    else $error("read request not answered by one read response");

  write_answered: assert property (@(posedge clock) disable iff (rst)
    manager_write_request |=> manager_write_response && !manager_read_response)
    else $error("write request not answered by one write response");

  // Responses only follow a request
  no_stray_response: assert property (@(posedge clock) disable iff (rst)
    (manager_read_response || manager_write_response)
      |-> $past(manager_read_request || manager_write_request))
    else $error("response without a request");

endmodule

/* testbench/soc_tb.sv */
/*
  Testbench for the SoC device side. It acts as the bus manager, keeps a
  reference model of the RAM, GPIO and timer registers, and checks every
  read response against the value that the model predicts.
  Six tests run in order, then the check and error counts are printed.
*/

`timescale 1ns/1ps

module soc_tb;

  import soc_pkg::*;

  localparam int memory_size    = 4096;
  localparam int gpio_width     = 4;
  localparam int timeout_cycles = 100;

  logic                    clock;
  logic                    rst;
  logic [31:0]             rw_address;
  logic [data_width-1:0]   read_data;
  logic                    read_request;
  logic                    read_response;
  logic [data_width-1:0]   write_data;
  logic [strobe_width-1:0] write_strobe;
  logic                    write_request;
  logic                    write_response;
  logic [gpio_width-1:0]   gpio_input;
  logic [gpio_width-1:0]   gpio_oe;
  logic [gpio_width-1:0]   gpio_output;
  logic                    irq_timer;

  // Reference model state
  logic [31:0]           ram_words [memory_size/4];
  logic                  timer_enable;
  logic [63:0]           timer_time;
  logic [63:0]           timer_cmp;
  logic [gpio_width-1:0] oe_model;
  logic [gpio_width-1:0] output_model;
  logic [31:0]           expected_queue [$];
  logic [31:0]           lfsr_state;
  int                    error_count;
  int                    check_count;
  int                    test_start_errors;

  soc_top #(.memory_size(memory_size), .gpio_width(gpio_width)) u_soc_top (.*);

  bind soc_bus soc_bus_sva u_soc_bus_sva (
    .clock                 (clock),
    .rst                   (rst),
    .manager_read_request  (manager_read_request),
    .manager_write_request (manager_write_request),
    .manager_read_response (manager_read_response),
    .manager_write_response(manager_write_response),
    .device_read_request   (device_read_request),
    .device_write_request  (device_write_request)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // ------------------------------------------------------------------
  // Random source and reference model
  // ------------------------------------------------------------------

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
    end
    return value;
  endfunction

  function automatic logic [31:0] byte_merge(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  strobe);
    logic [31:0] merged;
    merged = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strobe[i]) merged[8*i +: 8] = new_word[8*i +: 8];
    end
    return merged;
  endfunction

  // Expected read data for any address
  // Unmapped reads give zero
  function automatic logic [31:0] reference_read(input logic [31:0] address);
    logic [31:0] result;
    result = 32'h0;
    if ((address - ram_start) < 32'(memory_size)) begin
      result = ram_words[(address - ram_start) >> 2];
    end else if ((address - mtimer_start) < mtimer_size) begin
      case (address - mtimer_start)
        0:       result = {31'b0, timer_enable};
        4:       result = timer_time[31:0];
        8:       result = timer_time[63:32];
        12:      result = timer_cmp[31:0];
        16:      result = timer_cmp[63:32];
        default: result = 32'h0;
      endcase
    end else if ((address - gpio_start) < gpio_size) begin
      case (address - gpio_start)
        0:       result = 32'(gpio_input);
        4:       result = 32'(oe_model);
        8:       result = 32'(output_model);
        default: result = 32'h0;
      endcase
    end
    return result;
  endfunction

  task automatic model_write(input logic [31:0] address, input logic [31:0] data,
                             input logic [3:0] strobe);
    logic [31:0] index;
    if ((address - ram_start) < 32'(memory_size)) begin
      index            = (address - ram_start) >> 2;
      ram_words[index] = byte_merge(ram_words[index], data, strobe);
    end else if ((address - mtimer_start) < mtimer_size) begin
      case (address - mtimer_start)
        0:       if (strobe[0]) timer_enable = data[0];
        4:       timer_time[31:0]  = byte_merge(timer_time[31:0], data, strobe);
        8:       timer_time[63:32] = byte_merge(timer_time[63:32], data, strobe);
        12:      timer_cmp[31:0]   = byte_merge(timer_cmp[31:0], data, strobe);
        16:      timer_cmp[63:32]  = byte_merge(timer_cmp[63:32], data, strobe);
        default: ;
      endcase
    end else if ((address - gpio_start) < gpio_size && strobe[0]) begin
      if (address - gpio_start == 4) oe_model = data[gpio_width-1:0];
      if (address - gpio_start == 8) output_model = data[gpio_width-1:0];
    end
  endtask

  // ------------------------------------------------------------------
  // Checking and bus tasks
  // ------------------------------------------------------------------

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, actual, expected);
      error_count++;
    end
  endtask

  // Read data is compared against the value predicted at request time
  always @(negedge clock) begin
    if (read_response) begin
      if (expected_queue.size() == 0) begin
        $display("Read response at %0t without an outstanding read", $time);
        error_count++;
      end else begin
        check("read_data", read_data, expected_queue.pop_front());
      end
    end
  end

  // Called in the request cycle; the response is due one cycle later
  task automatic await_response(input logic is_write, input logic [31:0] address);
    int   cycles;
    logic responded;
    @(negedge clock);
    read_request  = 1'b0;
    write_request = 1'b0;
    cycles        = 1;
    responded     = is_write ? write_response : read_response;
    while (!responded && cycles < timeout_cycles) begin
      @(negedge clock);
      cycles++;
      responded = is_write ? write_response : read_response;
    end
    if (!responded) begin
      $display("No response to the access at %h within %0d cycles", address, timeout_cycles);
      error_count++;
    end else if (cycles != 1) begin
      $display("Response to the access at %h came %0d cycles late", address, cycles);
      error_count++;
    end
  endtask

  task automatic bus_write(input logic [31:0] address, input logic [31:0] data,
                           input logic [3:0] strobe);
    model_write(address, data, strobe);
    rw_address    = address;
    write_data    = data;
    write_strobe  = strobe;
    write_request = 1'b1;
    await_response(1'b1, address);
  endtask

  task automatic bus_read(input logic [31:0] address);
    expected_queue.push_back(reference_read(address));
    rw_address   = address;
    read_request = 1'b1;
    await_response(1'b0, address);
  endtask

  task automatic wait_irq(input logic level);
    int cycles;
    cycles = 0;
    while (irq_timer !== level && cycles < timeout_cycles) begin
      @(negedge clock);
      cycles++;
    end
    if (irq_timer !== level) begin
      $display("irq_timer did not reach %b within %0d cycles", level, timeout_cycles);
      error_count++;
    end
  endtask

  task automatic end_test(input string name);
    if (error_count == test_start_errors) $display("%s: ok", name);
    else $display("%s: %0d errors", name, error_count - test_start_errors);
    test_start_errors = error_count;
  endtask

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------

  initial begin
    logic [31:0] addresses [$];
    logic [31:0] address;
    rst           = 1'b1;
    rw_address    = '0;
    read_request  = 1'b0;
    write_request = 1'b0;
    write_data    = '0;
    write_strobe  = '0;
    gpio_input    = '0;
    timer_enable  = 1'b0;
    timer_time    = '0;
    timer_cmp     = '0;
    oe_model      = '0;
    output_model  = '0;
    lfsr_state    = 32'he9ad;
    error_count   = 0;
    check_count   = 0;
    test_start_errors = 0;
    repeat (3) @(negedge clock);
    rst = 1'b0;

    // Reset state
    check("gpio_oe", 32'(gpio_oe), 32'h0);
    check("gpio_output", 32'(gpio_output), 32'h0);
    check("irq_timer", 32'(irq_timer), 32'h0);
    check("read_response", 32'(read_response), 32'h0);
    check("write_response", 32'(write_response), 32'h0);
    bus_read(mtimer_start);
    bus_read(mtimer_start + 4);
    bus_read(gpio_start + 8);
    end_test("reset state");

    // Full words at random RAM addresses
    for (int i = 0; i < 8; i++) begin
      address = random_bits($clog2(memory_size) - 2) << 2;
      addresses.push_back(address);
      bus_write(address, random_bits(32), 4'hf);
    end
    foreach (addresses[i]) bus_read(addresses[i]);
    end_test("ram words");

    // Partial strobes merged over a known word
    for (int i = 0; i < 6; i++) begin
      address = random_bits($clog2(memory_size) - 2) << 2;
      addresses.push_back(address);
      bus_write(address, random_bits(32), 4'hf);
      repeat (3) bus_write(address, random_bits(32), 4'(random_bits(4)));
      bus_read(address);
    end
    end_test("byte strobes");

    // GPIO registers and synchronised inputs
    bus_write(gpio_start + 4, random_bits(32), 4'h1);
    bus_write(gpio_start + 8, random_bits(32), 4'h1);
    check("gpio_oe", 32'(gpio_oe), 32'(oe_model));
    check("gpio_output", 32'(gpio_output), 32'(output_model));
    bus_read(gpio_start + 4);
    bus_read(gpio_start + 8);
    gpio_input = gpio_width'(random_bits(gpio_width));
    repeat (3) @(negedge clock);
    bus_read(gpio_start);
    end_test("gpio");

    // Timer registers and then the interrupt
    bus_write(mtimer_start + 4, random_bits(32), 4'hf);
    bus_write(mtimer_start + 8, random_bits(31), 4'hf);
    bus_write(mtimer_start + 12, random_bits(32), 4'hf);
    bus_write(mtimer_start + 16, random_bits(32), 4'hf);
    for (int offset = 0; offset <= 16; offset += 4) bus_read(mtimer_start + offset);
    bus_write(mtimer_start + 16, 32'h0, 4'hf);
    bus_write(mtimer_start + 12, 32'h0, 4'hf);
    repeat (2) @(negedge clock);
    check("irq_timer", 32'(irq_timer), 32'h0);
    bus_write(mtimer_start, 32'h1, 4'hf);
    wait_irq(1'b1);
    bus_write(mtimer_start + 12, 32'hffff_ffff, 4'hf);
    bus_write(mtimer_start + 16, 32'hffff_ffff, 4'hf);
    wait_irq(1'b0);
    bus_write(mtimer_start, 32'h0, 4'hf);
    end_test("timer");

    // Unmapped accesses read zero and leave RAM alone
    bus_write(32'h0, random_bits(32), 4'hf);
    addresses.push_back(32'h0);
    bus_read(32'h4000_0000);
    bus_write(32'h4000_0000, random_bits(32), 4'hf);
    bus_read(32'h4000_0000);
    foreach (addresses[i]) bus_read(addresses[i]);
    end_test("unmapped");

    @(negedge clock);
    if (expected_queue.size() != 0) begin
      $display("%0d reads never got a response", expected_queue.size());
      error_count++;
    end
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
